// ==== hw/exe_pkg.sv ====
package exe_pkg;

    localparam int div_bits = 32;  // divider operand width

    typedef enum logic [4:0] {
        alu_add,
        alu_addu,
        alu_sub,
        alu_subu,
        alu_and,
        alu_or,
        alu_xor,
        alu_nor,
        alu_slt,
        alu_sltu,
        alu_sll,
        alu_srl,
        alu_sra,
        alu_lui,
        alu_div,
        alu_divu
    } alu_op_e;

    typedef enum logic [3:0] {
        mem_none,
        mem_lw,
        mem_lh,
        mem_lhu,
        mem_lb,
        mem_lbu,
        mem_sw,
        mem_sh,
        mem_sb,
        mem_swl,
        mem_swr
    } mem_op_e;

    // MIPS ExcCode values
    typedef enum logic [4:0] {
        exc_none = 5'd0,
        exc_adel = 5'd4,
        exc_ades = 5'd5,
        exc_ov   = 5'd12
    } exc_code_e;

    typedef enum logic [1:0] {
        src2_rt,
        src2_zimm,   // zero-extended imm
        src2_simm,   // sign-extended imm
        src2_eight   // link address offset
    } src2_sel_e;

    typedef struct packed {
        alu_op_e     alu_op;
        mem_op_e     mem_op;
        logic        src1_is_sa;
        logic        src1_is_pc;
        src2_sel_e   src2_sel;
        logic        gr_we;
        logic [4:0]  dest;
        logic [15:0] imm;
        logic [31:0] rs_value;
        logic [31:0] rt_value;
        logic [31:0] pc;
    } ds_to_es_t;

    typedef struct packed {
        logic        ex;
        exc_code_e   exc_code;
        mem_op_e     mem_op;
        logic        gr_we;
        logic [4:0]  dest;
        logic [31:0] result;  // alu result or memory address
        logic [31:0] aux;     // remainder or loaded word
        logic [31:0] pc;
    } es_to_ms_t;

    typedef struct packed {
        logic        wr;
        logic [31:0] addr;
        logic [3:0]  wstrb;
        logic [31:0] wdata;
    } dmem_req_t;

    function automatic logic is_load(mem_op_e op);
        return op inside {mem_lw, mem_lh, mem_lhu, mem_lb, mem_lbu};
    endfunction

    function automatic logic is_store(mem_op_e op);
        return op inside {mem_sw, mem_sh, mem_sb, mem_swl, mem_swr};
    endfunction

endpackage

// ==== hw/alu_divider.sv ====
module alu_divider (
    input  logic                         clk,
    input  logic                         reset,
    input  logic                         abort,
    input  logic                         start,
    input  logic                         is_signed,
    input  logic [exe_pkg::div_bits-1:0] dividend,
    input  logic [exe_pkg::div_bits-1:0] divisor,
    output logic [exe_pkg::div_bits-1:0] quotient,
    output logic [exe_pkg::div_bits-1:0] remainder,
    output logic                         busy,
    output logic                         done
);
    import exe_pkg::*;

    localparam int cnt_w = $clog2(div_bits + 1);

    logic [div_bits-1:0] rem_q;
    logic [div_bits-1:0] quo_q;  // shifts dividend out, quotient in
    logic [div_bits-1:0] dsr_q;
    logic [cnt_w-1:0]    count;
    logic                neg_q;
    logic                neg_r;
    logic                by_zero;
    logic                dvd_neg;
    logic                dsr_neg;
    logic [div_bits:0]   shifted;
    logic [div_bits:0]   diff;
    logic                fits;

    assign dvd_neg = is_signed && dividend[div_bits-1];
    assign dsr_neg = is_signed && divisor[div_bits-1];

    assign shifted = {rem_q, quo_q[div_bits-1]};
    assign diff    = shifted - {1'b0, dsr_q};
    assign fits    = shifted >= {1'b0, dsr_q};  // restoring step

    always_ff @(posedge clk) begin
        if (reset || abort) begin
            busy  <= 1'b0;
            done  <= 1'b0;
            count <= '0;
        end else begin
            done <= 1'b0;
            if (start) begin
                busy  <= 1'b1;
                count <= cnt_w'(div_bits);
            end else if (busy) begin
                count <= count - 1'b1;
                if (count == cnt_w'(1)) begin  // last iteration
                    busy <= 1'b0;
                    done <= 1'b1;
                end
            end
        end
    end

    always_ff @(posedge clk) begin
        if (start) begin
            rem_q   <= '0;
            quo_q   <= dvd_neg ? -dividend : dividend;
            dsr_q   <= dsr_neg ? -divisor : divisor;
            neg_q   <= dvd_neg ^ dsr_neg;
            neg_r   <= dvd_neg;
            by_zero <= divisor == '0;
        end else if (busy) begin
            rem_q <= fits ? diff[div_bits-1:0] : shifted[div_bits-1:0];
            quo_q <= {quo_q[div_bits-2:0], fits};
        end
    end

    // remainder follows the dividend sign, so /0 returns the dividend
    assign quotient  = by_zero ? '1 : (neg_q ? -quo_q : quo_q);
    assign remainder = neg_r ? -rem_q : rem_q;

    // the stage must hold off a new divide until this one ends
    assert property (@(posedge clk) disable iff (reset) start |-> !busy);

endmodule

// ==== hw/alu.sv ====
module alu (
    input  logic             clk,
    input  logic             reset,
    input  logic             flush,
    input  logic             start,
    input  exe_pkg::alu_op_e op,
    input  logic [31:0]      src1,
    input  logic [31:0]      src2,
    output logic [31:0]      result,
    output logic [31:0]      remainder,
    output logic             overflow,
    output logic             done
);
    import exe_pkg::*;

    logic [31:0] sum;
    logic [31:0] diff;
    logic [4:0]  sa;
    logic [31:0] comb_result;
    logic        is_div;
    logic        div_start;
    logic [31:0] div_quo;
    logic [31:0] div_rem;
    logic        div_done;

    assign sum  = src1 + src2;
    assign diff = src1 - src2;
    assign sa   = src1[4:0];

    always_comb begin
        comb_result = '0;
        overflow    = 1'b0;
        case (op)
            alu_add: begin
                comb_result = sum;
                overflow    = (src1[31] == src2[31]) && (sum[31] != src1[31]);
            end
            alu_sub: begin
                comb_result = diff;
                overflow    = (src1[31] != src2[31]) && (diff[31] != src1[31]);
            end
            alu_addu: comb_result = sum;
            alu_subu: comb_result = diff;
            alu_and:  comb_result = src1 & src2;
            alu_or:   comb_result = src1 | src2;
            alu_xor:  comb_result = src1 ^ src2;
            alu_nor:  comb_result = ~(src1 | src2);
            alu_slt:  comb_result = {31'b0, $signed(src1) < $signed(src2)};
            alu_sltu: comb_result = {31'b0, src1 < src2};
            alu_sll:  comb_result = src2 << sa;
            alu_srl:  comb_result = src2 >> sa;
            alu_sra:  comb_result = $unsigned($signed(src2) >>> sa);
            alu_lui:  comb_result = {src2[15:0], 16'b0};
            default:  comb_result = '0;  // div results come from the divider
        endcase
    end

    assign is_div    = (op == alu_div) || (op == alu_divu);
    assign div_start = start && is_div;

    alu_divider u_divider (
        .clk       (clk),
        .reset     (reset),
        .abort     (flush),
        .start     (div_start),
        .is_signed (op == alu_div),
        .dividend  (src1),
        .divisor   (src2),
        .quotient  (div_quo),
        .remainder (div_rem),
        .busy      (),
        .done      (div_done)
    );

    assign result    = is_div ? div_quo : comb_result;
    assign remainder = is_div ? div_rem : '0;
    assign done      = is_div ? div_done : 1'b1;  // single-cycle ops are ready at once

endmodule

// ==== hw/store_align.sv ====
module store_align (
    input  exe_pkg::mem_op_e mem_op,
    input  logic [1:0]       addr_low,
    input  logic [31:0]      rt_value,
    output logic [3:0]       wstrb,
    output logic [31:0]      wdata,
    output logic             ades,
    output logic             adel
);
    import exe_pkg::*;

    always_comb begin
        wstrb = 4'b0000;  // loads and non-memory ops
        wdata = rt_value;
        case (mem_op)
            mem_sb: begin
                wstrb = 4'b0001 << addr_low;
                wdata = {4{rt_value[7:0]}};
            end
            mem_sh: begin
                wstrb = addr_low[1] ? 4'b1100 : 4'b0011;
                wdata = {2{rt_value[15:0]}};
            end
            mem_sw: begin
                wstrb = 4'b1111;
            end
            // swl writes the upper bytes of rt into the low lanes
            mem_swl: begin
                wstrb = 4'b1111 >> ~addr_low;
                wdata = rt_value >> {~addr_low, 3'b000};
            end
            // swr writes the low bytes of rt from the addressed lane up
            mem_swr: begin
                wstrb = 4'b1111 << addr_low;
                wdata = rt_value << {addr_low, 3'b000};
            end
            default: begin
                wstrb = 4'b0000;
                wdata = rt_value;
            end
        endcase
    end

    assign ades = ((mem_op == mem_sh) && addr_low[0]) ||
                  ((mem_op == mem_sw) && (addr_low != 2'b00));

    assign adel = ((mem_op == mem_lh || mem_op == mem_lhu) && addr_low[0]) ||
                  ((mem_op == mem_lw) && (addr_low != 2'b00));

endmodule

// ==== hw/exe_stage.sv ====
module exe_stage (
    input  logic               clk,
    input  logic               reset,
    input  logic               flush,
    input  logic               in_valid,
    input  exe_pkg::ds_to_es_t in_bus,
    output logic               allowin,
    input  logic               ms_allowin,
    output logic               out_valid,
    output exe_pkg::es_to_ms_t out_bus,
    output logic               req_valid,
    output exe_pkg::dmem_req_t req,
    input  logic               addr_ok,
    input  logic               data_ok,
    input  logic [31:0]        rdata
);
    import exe_pkg::*;

    logic        es_valid;
    ds_to_es_t   bus_r;
    logic        started;   // request sent or divide launched
    logic        mem_done;  // data_ok seen
    logic        alu_done_r;
    logic [31:0] rdata_r;
    logic [31:0] src1;
    logic [31:0] src2;
    logic [31:0] alu_result;
    logic [31:0] alu_rem;
    logic        alu_overflow;
    logic        alu_done;
    logic [3:0]  wstrb;
    logic [31:0] wdata;
    logic        ades;
    logic        adel;
    logic        ex;
    exc_code_e   exc_code;
    logic        is_mem;
    logic        data_hit;
    logic        ready_go;

    assign is_mem = bus_r.mem_op != mem_none;

    assign src1 = bus_r.src1_is_sa ? {27'b0, bus_r.imm[10:6]} :
                  bus_r.src1_is_pc ? bus_r.pc : bus_r.rs_value;

    always_comb begin
        case (bus_r.src2_sel)
            src2_zimm:  src2 = {16'b0, bus_r.imm};
            src2_simm:  src2 = {{16{bus_r.imm[15]}}, bus_r.imm};
            src2_eight: src2 = 32'd8;
            default:    src2 = bus_r.rt_value;
        endcase
    end

    alu u_alu (
        .clk       (clk),
        .reset     (reset),
        .flush     (flush),
        .start     (es_valid && !started),
        .op        (bus_r.alu_op),
        .src1      (src1),
        .src2      (src2),
        .result    (alu_result),
        .remainder (alu_rem),
        .overflow  (alu_overflow),
        .done      (alu_done)
    );

    store_align u_store_align (
        .mem_op   (bus_r.mem_op),
        .addr_low (alu_result[1:0]),
        .rt_value (bus_r.rt_value),
        .wstrb    (wstrb),
        .wdata    (wdata),
        .ades     (ades),
        .adel     (adel)
    );

    assign ex       = alu_overflow | ades | adel;
    assign exc_code = alu_overflow ? exc_ov :
                      ades         ? exc_ades :
                      adel         ? exc_adel : exc_none;

    // a late data_ok from a flushed request finds started cleared
    assign data_hit = es_valid && started && !mem_done && data_ok;

    assign ready_go  = ex     ? 1'b1 :
                       is_mem ? (data_hit || mem_done) : (alu_done || alu_done_r);
    assign allowin   = !es_valid || (ready_go && ms_allowin);
    assign out_valid = es_valid && ready_go;

    always_ff @(posedge clk) begin
        if (reset || flush) begin
            es_valid   <= 1'b0;
            started    <= 1'b0;
            mem_done   <= 1'b0;
            alu_done_r <= 1'b0;
        end else if (allowin) begin
            es_valid   <= in_valid;
            started    <= 1'b0;
            mem_done   <= 1'b0;
            alu_done_r <= 1'b0;
        end else begin
            if (req_valid || !is_mem)
                started <= 1'b1;
            if (data_hit)
                mem_done <= 1'b1;
            if (alu_done)
                alu_done_r <= 1'b1;  // hold divider done under back-pressure
        end
    end

    always_ff @(posedge clk) begin
        if (in_valid && allowin)
            bus_r <= in_bus;
        if (data_hit)
            rdata_r <= rdata;
    end

    assign req_valid = es_valid && is_mem && !ex && !started && addr_ok;

    assign req.wr    = is_store(bus_r.mem_op);
    assign req.addr  = alu_result;
    assign req.wstrb = wstrb;
    assign req.wdata = wdata;

    always_comb begin
        out_bus          = '0;
        out_bus.ex       = ex;
        out_bus.exc_code = exc_code;
        out_bus.mem_op   = bus_r.mem_op;
        out_bus.gr_we    = bus_r.gr_we;
        out_bus.dest     = bus_r.dest;
        out_bus.result   = alu_result;
        out_bus.pc       = bus_r.pc;
        if (is_load(bus_r.mem_op))
            out_bus.aux = mem_done ? rdata_r : rdata;
        else
            out_bus.aux = alu_rem;
    end

    // only a legal load or store encoding reaches the RAM
    assert property (@(posedge clk) disable iff (reset)
        req_valid |-> (is_load(bus_r.mem_op) || is_store(bus_r.mem_op)) && !ex);

    // one request per instruction
    assert property (@(posedge clk) disable iff (reset)
        req_valid |=> !req_valid);

    assert property (@(posedge clk) disable iff (reset)
        out_valid && !ms_allowin && !flush |=> out_valid && $stable(out_bus));

endmodule

// ==== hw/data_ram.sv ====
module data_ram #(
    parameter int ram_words = 256
) (
    input  logic               clk,
    input  logic               reset,
    input  logic               req_valid,
    input  exe_pkg::dmem_req_t req,
    output logic               addr_ok,
    output logic               data_ok,
    output logic [31:0]        rdata
);

    logic [31:0] mem [ram_words];
    logic [31:0] index;

    assign index   = (req.addr >> 2) % ram_words;  // word index, wraps at depth
    assign addr_ok = 1'b1;  // always accepts

    always_ff @(posedge clk) begin
        if (reset)
            data_ok <= 1'b0;
        else
            data_ok <= req_valid;  // response one cycle after accept
    end

    always_ff @(posedge clk) begin
        if (req_valid) begin
            rdata <= mem[index];  // old word on writes
            if (req.wr) begin
                for (int i = 0; i < 4; i++) begin
                    if (req.wstrb[i])
                        mem[index][8*i +: 8] <= req.wdata[8*i +: 8];
                end
            end
        end
    end

endmodule

// ==== hw/exe_top.sv ====
module exe_top #(
    parameter int ram_words = 256
) (
    input  logic               clk,
    input  logic               reset,
    input  logic               flush,
    input  logic               in_valid,
    input  exe_pkg::ds_to_es_t in_bus,
    output logic               allowin,
    input  logic               ms_allowin,
    output logic               out_valid,
    output exe_pkg::es_to_ms_t out_bus
);
    import exe_pkg::*;

    logic        req_valid;
    dmem_req_t   req;
    logic        addr_ok;
    logic        data_ok;
    logic [31:0] rdata;

    exe_stage u_exe_stage (
        .clk        (clk),
        .reset      (reset),
        .flush      (flush),
        .in_valid   (in_valid),
        .in_bus     (in_bus),
        .allowin    (allowin),
        .ms_allowin (ms_allowin),
        .out_valid  (out_valid),
        .out_bus    (out_bus),
        .req_valid  (req_valid),
        .req        (req),
        .addr_ok    (addr_ok),
        .data_ok    (data_ok),
        .rdata      (rdata)
    );

    data_ram #(
        .ram_words (ram_words)
    ) u_data_ram (
        .clk       (clk),
        .reset     (reset),
        .req_valid (req_valid),
        .req       (req),
        .addr_ok   (addr_ok),
        .data_ok   (data_ok),
        .rdata     (rdata)
    );

endmodule

// ==== tb/exe_tb.sv ====
module exe_tb;
    import exe_pkg::*;

    logic      clk;
    logic      reset;
    logic      flush;
    logic      in_valid;
    ds_to_es_t in_bus;
    logic      allowin;
    logic      ms_allowin;
    logic      out_valid;
    es_to_ms_t out_bus;

    logic [8*32-1:0] test_name;
    logic [31:0]     v_alu, v_mem, v_src1, v_src2, v_imm, v_rs, v_rt;
    logic [31:0]     v_bp, v_ex, v_exc, v_result, v_aux;
    int              errors;
    int              timeouts;
    int              vectors;

    exe_top #(
        .ram_words (256)
    ) UUT (
        .clk        (clk),
        .reset      (reset),
        .flush      (flush),
        .in_valid   (in_valid),
        .in_bus     (in_bus),
        .allowin    (allowin),
        .ms_allowin (ms_allowin),
        .out_valid  (out_valid),
        .out_bus    (out_bus)
    );

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    task automatic compare_field(input string field, input logic [31:0] expected,
                                 input logic [31:0] actual);
        if (actual !== expected) begin
            $display("error %0s %0s: expected %h, actual %h", test_name, field, expected, actual);
            errors++;
        end
    endtask

    task automatic wait_allowin();
        int n;
        n = 0;
        while (!allowin && n < 100) begin
            @(posedge clk);
            #1;
            n++;
        end
        if (!allowin) begin
            $display("timeout: allowin stayed low in %0s", test_name);
            timeouts++;
        end
    endtask

    task automatic wait_out_valid(output int cycles);
        int n;
        n = 0;
        while (!out_valid && n < 100) begin
            @(posedge clk);
            #1;
            n++;
        end
        cycles = n;
        if (!out_valid) begin
            $display("timeout: out_valid never rose in %0s", test_name);
            timeouts++;
        end
    endtask

    // hold in_valid for exactly the accepting edge
    task automatic send_instr(input ds_to_es_t bus);
        wait_allowin();
        if (timeouts != 0)
            return;
        in_valid = 1'b1;
        in_bus   = bus;
        @(posedge clk);
        #1;
        in_valid = 1'b0;
    endtask

    task automatic flush_divide();
        ds_to_es_t bus;
        bus          = '0;
        bus.alu_op   = alu_div;
        bus.rs_value = 32'd100;
        bus.rt_value = 32'd7;
        bus.pc       = 32'hbfc00100;
        test_name    = "flush_div";
        ms_allowin   = 1'b1;
        send_instr(bus);
        if (timeouts != 0)
            return;
        repeat (5) begin
            @(posedge clk);
            #1;
        end
        flush = 1'b1;  // mid-divide
        @(posedge clk);
        #1;
        flush = 1'b0;
        repeat (40) begin  // well past the normal divide latency
            @(posedge clk);
            #1;
            if (out_valid) begin
                $display("%0s: flushed divide still produced an output", test_name);
                errors++;
            end
        end
    endtask

    task automatic run_vector();
        ds_to_es_t bus;
        es_to_ms_t held;
        int        lat;
        int        exp_lat;
        bus            = '0;
        bus.alu_op     = alu_op_e'(v_alu[4:0]);
        bus.mem_op     = mem_op_e'(v_mem[3:0]);
        bus.src1_is_sa = (v_src1 == 32'd1);
        bus.src1_is_pc = (v_src1 == 32'd2);
        bus.src2_sel   = src2_sel_e'(v_src2[1:0]);
        bus.gr_we      = vectors[0];        // toggles per vector
        bus.dest       = 5'(vectors + 1);
        bus.imm        = v_imm[15:0];
        bus.rs_value   = v_rs;
        bus.rt_value   = v_rt;
        bus.pc         = 32'hbfc00100;
        // latency from the accepting edge
        if (v_ex != 0)
            exp_lat = 0;
        else if (v_mem != 0)
            exp_lat = 1;
        else if (v_alu == 32'he || v_alu == 32'hf)
            exp_lat = 33;
        else
            exp_lat = 0;
        ms_allowin = (v_bp == 0);
        send_instr(bus);
        if (timeouts != 0)
            return;
        wait_out_valid(lat);
        if (timeouts != 0)
            return;
        if (lat != exp_lat) begin
            $display("error %0s latency: expected %0d, actual %0d", test_name, exp_lat, lat);
            errors++;
        end
        held = out_bus;
        repeat (v_bp) begin
            @(posedge clk);
            #1;
            if (!out_valid || allowin) begin
                $display("%0s: out_valid fell or allowin rose under back-pressure", test_name);
                errors++;
            end
            if (out_bus !== held) begin
                $display("error %0s held out_bus: expected %h, actual %h",
                         test_name, held, out_bus);
                errors++;
            end
        end
        ms_allowin = 1'b1;
        compare_field("ex", v_ex, {31'b0, held.ex});
        compare_field("exc_code", v_exc, {27'b0, held.exc_code});
        compare_field("mem_op", v_mem, {28'b0, held.mem_op});
        compare_field("gr_we", {31'b0, bus.gr_we}, {31'b0, held.gr_we});
        compare_field("dest", {27'b0, bus.dest}, {27'b0, held.dest});
        compare_field("result", v_result, held.result);
        compare_field("pc", 32'hbfc00100, held.pc);
        if (v_ex == 0)
            compare_field("aux", v_aux, held.aux);
        @(posedge clk);
        #1;
        if (out_valid) begin
            $display("%0s: instruction delivered more than once", test_name);
            errors++;
        end
    endtask

    initial begin
        int    fd;
        int    n;
        string line;
        errors     = 0;
        timeouts   = 0;
        vectors    = 0;
        reset      = 1'b1;
        flush      = 1'b0;
        in_valid   = 1'b0;
        in_bus     = '0;
        ms_allowin = 1'b1;
        test_name  = "reset";
        void'($urandom(32'h2f001b62));
        repeat (16) @(posedge clk);
        #1;
        reset = 1'b0;
        if (!allowin || out_valid) begin
            $display("stage not empty after reset");
            errors++;
        end
        flush_divide();
        fd = $fopen("tb/exe_tests.txt", "r");
        if (fd == 0) begin
            $display("could not open tb/exe_tests.txt");
            errors++;
        end else begin
            while (timeouts == 0 && $fgets(line, fd) > 0) begin
                if (line.len() < 2 || line.getc(0) == "#")
                    continue;
                n = $sscanf(line, "%s %h %h %h %h %h %h %h %d %h %h %h %h", test_name,
                            v_alu, v_mem, v_src1, v_src2, v_imm, v_rs, v_rt,
                            v_bp, v_ex, v_exc, v_result, v_aux);
                if (n != 13) begin
                    $display("malformed vector line: %0s", line);
                    errors++;
                    continue;
                end
                repeat ($urandom % 3) begin  // idle gap
                    @(posedge clk);
                    #1;
                end
                run_vector();
                vectors++;
            end
            $fclose(fd);
        end
        $display("vectors %0d, errors %0d, timeouts %0d", vectors, errors, timeouts);
        if (errors == 0 && timeouts == 0 && vectors > 0)
            $display("Test passed");
        else
            $display("Test failed");
        $finish;
    end

endmodule

// ==== tb/exe_tests.txt ====
# name alu_op mem_op src1(0 rs,1 sa,2 pc) src2_sel imm rs rt backpressure ex exc_code result aux
# all hex except backpressure (cycles, decimal); aux is ignored when ex is 1
div_after_flush e 0 0 0 0000 fffffff9 00000002 0 0 00 fffffffd ffffffff
add_basic       0 0 0 0 0000 00000005 00000007 0 0 00 0000000c 00000000
add_ovf         0 0 0 0 0000 7fffffff 00000001 0 1 0c 80000000 00000000
addu_wrap       1 0 0 0 0000 7fffffff 00000001 0 0 00 80000000 00000000
sub_ovf         2 0 0 0 0000 80000000 00000001 0 1 0c 7fffffff 00000000
subu_wrap       3 0 0 0 0000 00000000 00000001 0 0 00 ffffffff 00000000
addi_neg        0 0 0 2 fff0 00000020 00000000 0 0 00 00000010 00000000
and_reg         4 0 0 0 0000 f0f0f0f0 ff00ff00 0 0 00 f000f000 00000000
ori_zimm        5 0 0 1 8001 12340000 00000000 0 0 00 12348001 00000000
xor_reg         6 0 0 0 0000 aaaa5555 ffff0000 0 0 00 55555555 00000000
nor_reg         7 0 0 0 0000 0f0f0000 00000f0f 0 0 00 f0f0f0f0 00000000
slt_signed      8 0 0 0 0000 ffffffff 00000001 0 0 00 00000001 00000000
sltu_unsigned   9 0 0 0 0000 ffffffff 00000001 0 0 00 00000000 00000000
slti_simm       8 0 0 2 8000 ffff0000 00000000 0 0 00 00000001 00000000
sll_sa4         a 0 1 0 0100 00000000 0000000f 0 0 00 000000f0 00000000
srl_sa8         b 0 1 0 0200 00000000 80000000 0 0 00 00800000 00000000
sra_sa8         c 0 1 0 0200 00000000 80000000 0 0 00 ff800000 00000000
srav_rs         c 0 0 0 0000 00000024 f0000000 0 0 00 ff000000 00000000
lui_imm         d 0 0 1 1234 00000000 00000000 0 0 00 12340000 00000000
link_pc8        1 0 2 3 0000 00000000 00000000 0 0 00 bfc00108 00000000
divu_big        f 0 0 0 0000 fffffff9 00000002 0 0 00 7ffffffc 00000001
div_neg_divisor e 0 0 0 0000 00000007 fffffffe 0 0 00 fffffffd 00000001
div_by_zero     e 0 0 0 0000 00000007 00000000 0 0 00 ffffffff 00000007
add_held        0 0 0 0 0000 00000001 00000002 5 0 00 00000003 00000000
div_held        e 0 0 0 0000 00000064 00000007 3 0 00 0000000e 00000002
sw_word         1 6 0 2 0000 00000100 11223344 0 0 00 00000100 00000000
sb_lane1        1 8 0 2 0001 00000100 000000aa 0 0 00 00000101 00000000
sh_upper        1 7 0 2 0002 00000100 0000bbcc 0 0 00 00000102 00000000
lw_merge        1 1 0 2 0000 00000100 00000000 0 0 00 00000100 bbccaa44
sw_second       1 6 0 2 0004 00000100 55667788 0 0 00 00000104 00000000
swl_off1        1 9 0 2 0005 00000100 a1b2c3d4 0 0 00 00000105 00000000
swr_off2        1 a 0 2 0006 00000100 e5f60718 0 0 00 00000106 00000000
lw_partial      1 1 0 2 0004 00000100 00000000 2 0 00 00000104 0718a1b2
lb_full         1 4 0 2 0003 00000100 00000000 0 0 00 00000103 bbccaa44
lhu_full        1 3 0 2 0002 00000100 00000000 0 0 00 00000102 bbccaa44
lbu_full        1 5 0 2 0001 00000100 00000000 0 0 00 00000101 bbccaa44
sh_misalign     1 7 0 2 0001 00000100 0000dead 0 1 05 00000101 00000000
sw_misalign     1 6 0 2 0002 00000100 ffffffff 0 1 05 00000102 00000000
lw_misalign     1 1 0 2 0001 00000100 00000000 0 1 04 00000101 00000000
lh_misalign     1 2 0 2 0003 00000100 00000000 0 1 04 00000103 00000000
lhu_misalign    1 3 0 2 0001 00000100 00000000 0 1 04 00000101 00000000
lw_unchanged    1 1 0 2 0000 00000100 00000000 4 0 00 00000100 bbccaa44

// ==== filelist.f ====
hw/exe_pkg.sv
hw/alu_divider.sv
hw/alu.sv
hw/store_align.sv
hw/exe_stage.sv
hw/data_ram.sv
hw/exe_top.sv
tb/exe_tb.sv

// ==== run.sh ====
#!/usr/bin/env bash
# Build and run the execute stage testbench with Verilator.
set -u
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal -f filelist.f --top-module exe_tb \
    -o exe_sim > build.log 2>&1
if [ $? -ne 0 ]; then
    echo "build failed, see build.log"
    exit 1
fi

./obj_dir/exe_sim > sim.log 2>&1
if [ $? -ne 0 ]; then
    echo "simulation exited with an error, see sim.log"
    exit 1
fi

if grep -qx "Test passed" sim.log; then
    echo "PASS"
    exit 0
fi
echo "FAIL, see sim.log"
exit 1
